/* include/rv_core_config.svh */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Architectural register count, x0 included
`define RV_REG_COUNT 32

// Data RAM depth in 32-bit words
`define RV_DMEM_WORDS 256

// First fetch address after reset
`define RV_RESET_PC 0

`endif

/* hdl/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // Supported major opcodes
    localparam opcode_t OP_R      = 7'b0110011;
    localparam opcode_t OP_I      = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;   // Operand b from the immediate
        logic    reg_we;
        logic    mem_re;
        logic    mem_we;
        logic    branch;
    } ctrl_t;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        funct3_t   funct3;
        funct7_t   funct7;
        opcode_t   opcode;
    } dec_t;

endpackage

`default_nettype wire

/* hdl/decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module decoder (
    input  rv_core_pkg::word_t inst,
    output rv_core_pkg::dec_t  dec
);

    always_comb begin
        dec = '0;
        dec.opcode = inst[6:0];

        case (dec.opcode)
            rv_core_pkg::OP_R: begin
                dec.rd     = inst[11:7];
                dec.funct3 = inst[14:12];
                dec.rs1    = inst[19:15];
                dec.rs2    = inst[24:20];
                dec.funct7 = inst[31:25];
            end

            rv_core_pkg::OP_I: begin
                dec.rd     = inst[11:7];
                dec.funct3 = inst[14:12];
                dec.rs1    = inst[19:15];
                dec.imm    = {{20{inst[31]}}, inst[31:20]};
                // Shift immediates carry the SRAI select in the upper bits
                if (inst[13:12] == 2'b01) begin
                    dec.funct7 = inst[31:25];
                end
            end

            rv_core_pkg::OP_LOAD: begin
                dec.rd     = inst[11:7];
                dec.funct3 = inst[14:12];
                dec.rs1    = inst[19:15];
                dec.imm    = {{20{inst[31]}}, inst[31:20]};
            end

            rv_core_pkg::OP_STORE: begin
                dec.funct3 = inst[14:12];
                dec.rs1    = inst[19:15];
                dec.rs2    = inst[24:20];
                dec.imm    = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end

            rv_core_pkg::OP_BRANCH: begin
                dec.funct3 = inst[14:12];
                dec.rs1    = inst[19:15];
                dec.rs2    = inst[24:20];
                dec.imm    = {{19{inst[31]}}, inst[31], inst[7],
                              inst[30:25], inst[11:8], 1'b0};  // Halfword offset
            end

            default: begin
                // Unknown opcode runs as a no-op
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  rv_core_pkg::opcode_t opcode,
    input  rv_core_pkg::funct3_t funct3,
    input  rv_core_pkg::funct7_t funct7,
    output rv_core_pkg::ctrl_t   ctrl
);

    rv_core_pkg::alu_op_e arith_op;
    logic                 alt;

    // SUB only exists in register form
    assign alt = funct7[5] && ((opcode == rv_core_pkg::OP_R) || (funct3 == 3'b101));

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (alt && opcode == rv_core_pkg::OP_R) ?
                                rv_core_pkg::SUB : rv_core_pkg::ADD;
            3'b001:  arith_op = rv_core_pkg::SLL;
            3'b010:  arith_op = rv_core_pkg::SLT;
            3'b011:  arith_op = rv_core_pkg::SLTU;
            3'b100:  arith_op = rv_core_pkg::XOR;
            3'b101:  arith_op = alt ? rv_core_pkg::SRA : rv_core_pkg::SRL;
            3'b110:  arith_op = rv_core_pkg::OR;
            default: arith_op = rv_core_pkg::AND;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (opcode)
            rv_core_pkg::OP_R: begin
                ctrl.alu_op = arith_op;
                ctrl.reg_we = 1'b1;
            end
            rv_core_pkg::OP_I: begin
                ctrl.alu_op  = arith_op;
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
            end
            rv_core_pkg::OP_LOAD: begin
                ctrl.use_imm = 1'b1;  // Address is rs1 plus offset
                ctrl.reg_we  = 1'b1;
                ctrl.mem_re  = 1'b1;
            end
            rv_core_pkg::OP_STORE: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = 1'b1;
            end
            rv_core_pkg::OP_BRANCH: ctrl.branch = 1'b1;  // Compares rs1 with rs2
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  rv_core_pkg::alu_op_e op,
    input  rv_core_pkg::word_t   a,
    input  rv_core_pkg::word_t   b,
    input  logic                 branch,
    input  rv_core_pkg::funct3_t funct3,
    output rv_core_pkg::word_t   result,
    output logic                 take_branch
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            rv_core_pkg::ADD:  result = a + b;
            rv_core_pkg::SUB:  result = a - b;
            rv_core_pkg::SLL:  result = a << shamt;
            rv_core_pkg::SLT:  result = {31'd0, lt_s};
            rv_core_pkg::SLTU: result = {31'd0, lt_u};
            rv_core_pkg::XOR:  result = a ^ b;
            rv_core_pkg::SRL:  result = a >> shamt;
            rv_core_pkg::SRA:  result = rv_core_pkg::word_t'($signed(a) >>> shamt);
            rv_core_pkg::OR:   result = a | b;
            rv_core_pkg::AND:  result = a & b;
            default:           result = '0;
        endcase
    end

    always_comb begin
        take_branch = 1'b0;
        if (branch) begin
            case (funct3)
                3'b000:  take_branch = (a == b);
                3'b001:  take_branch = (a != b);
                3'b100:  take_branch = lt_s;
                3'b101:  take_branch = !lt_s;
                3'b110:  take_branch = lt_u;
                3'b111:  take_branch = !lt_u;
                default: take_branch = 1'b0;  // 2 and 3 are reserved
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_config.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_core_pkg::reg_addr_t rs1,
    input  rv_core_pkg::reg_addr_t rs2,
    input  rv_core_pkg::reg_addr_t rd,
    input  logic                   we,
    input  rv_core_pkg::word_t     wdata,
    output rv_core_pkg::word_t     rdata1,
    output rv_core_pkg::word_t     rdata2
);

    rv_core_pkg::word_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero whatever the array holds
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    // Last cycle's write seen through either read port
    assert property (@(posedge clk) disable iff (!rst_n)
        (we && rd != '0) |=>
            ((rs1 != $past(rd) || rdata1 == $past(wdata)) &&
             (rs2 != $past(rd) || rdata2 == $past(wdata))));

endmodule

`default_nettype wire

/* hdl/data_mem.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_config.svh"

module data_mem (
    input  logic               clk,
    input  logic               we,
    input  logic               re,
    input  rv_core_pkg::word_t addr,
    input  rv_core_pkg::word_t wdata,
    output rv_core_pkg::word_t rdata
);

    localparam int IDX_W = $clog2(`RV_DMEM_WORDS);

    rv_core_pkg::word_t mem [`RV_DMEM_WORDS];
    logic [IDX_W-1:0]   idx;

    assign idx = addr[IDX_W+1:2];  // Byte address to word index

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

    // Only whole-word accesses are supported
    assert property (@(posedge clk) (we || re) |-> (addr[1:0] == 2'b00));

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_config.svh"

module rv_core (
    input  logic                   clk,
    input  logic                   rst_n,
    output rv_core_pkg::word_t     pc,
    input  rv_core_pkg::word_t     inst,
    output logic                   wb_en,
    output rv_core_pkg::reg_addr_t wb_addr,
    output rv_core_pkg::word_t     wb_data
);

    rv_core_pkg::dec_t  dec;
    rv_core_pkg::ctrl_t ctrl;
    rv_core_pkg::word_t rs1_data;
    rv_core_pkg::word_t rs2_data;
    rv_core_pkg::word_t alu_b;
    rv_core_pkg::word_t alu_result;
    rv_core_pkg::word_t mem_rdata;
    rv_core_pkg::word_t next_pc;
    logic               take_branch;
    logic               mem_we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= rv_core_pkg::word_t'(`RV_RESET_PC);
        end else begin
            pc <= next_pc;
        end
    end

    assign next_pc = take_branch ? pc + dec.imm : pc + 32'd4;

    decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    control_unit u_control_unit (
        .opcode (dec.opcode),
        .funct3 (dec.funct3),
        .funct7 (dec.funct7),
        .ctrl   (ctrl)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rd     (wb_addr),
        .we     (wb_en),
        .wdata  (wb_data),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    assign alu_b = ctrl.use_imm ? dec.imm : rs2_data;

    alu u_alu (
        .op          (ctrl.alu_op),
        .a           (rs1_data),
        .b           (alu_b),
        .branch      (ctrl.branch),
        .funct3      (dec.funct3),
        .result      (alu_result),
        .take_branch (take_branch)
    );

    assign mem_we = ctrl.mem_we && rst_n;  // No stores while in reset

    data_mem u_data_mem (
        .clk   (clk),
        .we    (mem_we),
        .re    (ctrl.mem_re),
        .addr  (alu_result),
        .wdata (rs2_data),
        .rdata (mem_rdata)
    );

    // Write-back of the instruction now on inst
    assign wb_en   = ctrl.reg_we && (dec.rd != '0) && rst_n;
    assign wb_addr = dec.rd;
    assign wb_data = ctrl.mem_re ? mem_rdata : alu_result;

endmodule

`default_nettype wire

/* dv/rv_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_core_config.svh"

module rv_core_tb;

    localparam int                 CLK_HALF     = 50;
    localparam int                 RESET_CYCLES = 3;
    localparam int                 IMEM_AW      = 8;
    localparam int                 IMEM_WORDS   = 1 << IMEM_AW;
    localparam int                 RESET_IDX    = (`RV_RESET_PC >> 2) & (IMEM_WORDS - 1);
    localparam rv_core_pkg::word_t SELF_LOOP    = 32'h0000_0063;  // beq x0, x0, 0
    localparam rv_core_pkg::word_t RESET_PROBE  = 32'h0010_0093;  // addi x1, x0, 1
    localparam string              STIM_FILE    = "dv/rv_core_stimulus.txt";

    typedef struct packed {
        rv_core_pkg::reg_addr_t addr;
        rv_core_pkg::word_t     data;
    } wb_rec_t;

    logic                   clk;
    logic                   rst_n;
    rv_core_pkg::word_t     pc;
    rv_core_pkg::word_t     inst;
    logic                   wb_en;
    rv_core_pkg::reg_addr_t wb_addr;
    rv_core_pkg::word_t     wb_data;

    rv_core_pkg::word_t imem [IMEM_WORDS];
    wb_rec_t            expected [$];
    int                 prog_len;
    bit                 loaded;

    rv_core u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .pc      (pc),
        .inst    (inst),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    // Instruction memory answers in the same cycle
    always_comb begin
        if (pc[31:IMEM_AW+2] == '0) begin
            inst = imem[pc[IMEM_AW+1:2]];
        end else begin
            inst = SELF_LOOP;
        end
    end

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic load_stimulus();
        int                 fd;
        int                 c;
        int                 n;
        byte                tag;
        logic [31:0]        reg_idx;
        rv_core_pkg::word_t value;
        wb_rec_t            rec;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("Cannot open the stimulus file");
        end
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = SELF_LOOP;  // Runs past the program end stay put
        end
        prog_len = 0;
        c = $fgetc(fd);
        while (c != -1) begin
            tag = byte'(c);
            if (tag == "#") begin
                while (c != -1 && c != 10) begin
                    c = $fgetc(fd);
                end
            end else if (tag == "P") begin
                n = $fscanf(fd, "%h", value);
                if (n != 1 || prog_len >= IMEM_WORDS) begin
                    abort_run("Malformed or oversized program in the stimulus file");
                end
                imem[prog_len] = value;
                prog_len++;
            end else if (tag == "E") begin
                n = $fscanf(fd, "%h %h", reg_idx, value);
                if (n != 2 || reg_idx >= `RV_REG_COUNT) begin
                    abort_run("Malformed write-back record in the stimulus file");
                end
                rec.addr = reg_idx[4:0];
                rec.data = value;
                expected.push_back(rec);
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    task automatic check_writeback(input wb_rec_t rec);
        assert (wb_addr == rec.addr) else begin
            abort_run($sformatf("FAIL wb_addr expected %h actual %h", rec.addr, wb_addr));
        end
        assert (wb_data == rec.data) else begin
            abort_run($sformatf("FAIL wb_data expected %h actual %h", rec.data, wb_data));
        end
    endtask

    initial begin
        int                 rec_idx;
        rv_core_pkg::word_t first_word;
        rst_n = 1'b0;
        load_stimulus();
        loaded = 1'b1;
        // Reset has to hold off a real register write at the reset address
        first_word       = imem[RESET_IDX];
        imem[RESET_IDX] = RESET_PROBE;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (wb_en == 1'b0) else begin
                abort_run("Write-back strobe went high while reset was asserted");
            end
        end
        assert (pc == rv_core_pkg::word_t'(`RV_RESET_PC)) else begin
            abort_run($sformatf("FAIL pc expected %h actual %h",
                                rv_core_pkg::word_t'(`RV_RESET_PC), pc));
        end
        imem[RESET_IDX] = first_word;
        rst_n = 1'b1;
        rec_idx = 0;
        while (rec_idx < expected.size()) begin
            @(negedge clk);
            if (wb_en) begin
                check_writeback(expected[rec_idx]);
                rec_idx++;
            end
        end
        $display("Simulation passed");
        $finish;
    end

    // Four cycles per word and per record is far more than the program needs
    initial begin
        int limit;
        wait (loaded);
        limit = (expected.size() + prog_len) * 4 + RESET_CYCLES;
        repeat (limit) @(posedge clk);
        abort_run($sformatf("Timeout after %0d cycles before the last expected write-back",
                            limit));
    end

endmodule

`default_nettype wire

/* dv/rv_core_stimulus.txt */
# P <instruction word, hex>            program words in address order from 0
# E <rd, hex> <value, hex>             expected write-backs in retire order
P 00000013  # nop, retires while reset is released
P 06400093  # addi x1, x0, 100
P FF900113  # addi x2, x0, -7
P 002081B3  # add  x3, x1, x2
P 40110233  # sub  x4, x2, x1
P 0F014293  # xori x5, x2, 0xf0
P FF017393  # andi x7, x2, -16
P 00409413  # slli x8, x1, 4
P 40215493  # srai x9, x2, 2
P 01C15513  # srli x10, x2, 28
P 001125B3  # slt  x11, x2, x1
P 00113633  # sltu x12, x2, x1
P 03708013  # addi x0, x1, 55
P 00100733  # add  x14, x0, x1
P 04000793  # addi x15, x0, 0x40
P 0047A423  # sw   x4, 8(x15)
P 01078813  # addi x16, x15, 16
P FF882883  # lw   x17, -8(x16)
P 12345937  # lui  x18, 0x12345
P 00100913  # addi x18, x0, 1
P 00208463  # beq  x1, x2, +8
P 00E08463  # beq  x1, x14, +8
P FFF00F93  # addi x31, x0, -1
P 00E09463  # bne  x1, x14, +8
P 00209463  # bne  x1, x2, +8
P FFF00F93  # addi x31, x0, -1
P 0020C463  # blt  x1, x2, +8
P 00114463  # blt  x2, x1, +8
P FFF00F93  # addi x31, x0, -1
P 00115463  # bge  x2, x1, +8
P 0020D463  # bge  x1, x2, +8
P FFF00F93  # addi x31, x0, -1
P 00116463  # bltu x2, x1, +8
P 0020E463  # bltu x1, x2, +8
P FFF00F93  # addi x31, x0, -1
P 0020F463  # bgeu x1, x2, +8
P 00117463  # bgeu x2, x1, +8
P FFF00F93  # addi x31, x0, -1
P 02A00A13  # addi x20, x0, 42
E 01 00000064
E 02 FFFFFFF9
E 03 0000005D
E 04 FFFFFF95
E 05 FFFFFF09
E 07 FFFFFFF0
E 08 00000640
E 09 FFFFFFFE
E 0A 0000000F
E 0B 00000001
E 0C 00000000
E 0E 00000064
E 0F 00000040
E 10 00000050
E 11 FFFFFF95
E 12 00000001
E 14 0000002A

/* vlog.f */
+incdir+include
hdl/rv_core_pkg.sv
hdl/decoder.sv
hdl/control_unit.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/data_mem.sv
hdl/rv_core.sv
dv/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES  := $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)
STIMULUS := dv/rv_core_stimulus.txt
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) $(STIMULUS)
	-$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation passed" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
